// ==== design/cpuPkg.sv ====
package cpuPkg;

    localparam int dataWidth    = 32;
    localparam int regAddrWidth = 5;
    localparam int regCount     = 32;
    localparam int ramWords     = 64;                    // Data RAM depth in words
    localparam int ramAddrWidth = $clog2(ramWords);      // Word index bits, upper bits wrap

    typedef logic [dataWidth-1:0]    wordT;
    typedef logic [regAddrWidth-1:0] regAddrT;

    localparam regAddrT linkReg = 5'd31;                 // JAL return address register

    // Major opcodes
    localparam logic [5:0] opSpecial = 6'b000000;
    localparam logic [5:0] opJ       = 6'b000010;
    localparam logic [5:0] opJal     = 6'b000011;
    localparam logic [5:0] opBeq     = 6'b000100;
    localparam logic [5:0] opBne     = 6'b000101;
    localparam logic [5:0] opBlez    = 6'b000110;
    localparam logic [5:0] opBgtz    = 6'b000111;
    localparam logic [5:0] opAddi    = 6'b001000;
    localparam logic [5:0] opAddiu   = 6'b001001;
    localparam logic [5:0] opSlti    = 6'b001010;
    localparam logic [5:0] opSltiu   = 6'b001011;
    localparam logic [5:0] opAndi    = 6'b001100;
    localparam logic [5:0] opOri     = 6'b001101;
    localparam logic [5:0] opXori    = 6'b001110;
    localparam logic [5:0] opLui     = 6'b001111;
    localparam logic [5:0] opLb      = 6'b100000;
    localparam logic [5:0] opLh      = 6'b100001;
    localparam logic [5:0] opLw      = 6'b100011;
    localparam logic [5:0] opLbu     = 6'b100100;
    localparam logic [5:0] opLhu     = 6'b100101;
    localparam logic [5:0] opSb      = 6'b101000;
    localparam logic [5:0] opSh      = 6'b101001;
    localparam logic [5:0] opSw      = 6'b101011;

    // SPECIAL function field
    localparam logic [5:0] fnSll  = 6'b000000;
    localparam logic [5:0] fnSrl  = 6'b000010;
    localparam logic [5:0] fnSra  = 6'b000011;
    localparam logic [5:0] fnSllv = 6'b000100;
    localparam logic [5:0] fnSrlv = 6'b000110;
    localparam logic [5:0] fnSrav = 6'b000111;
    localparam logic [5:0] fnJr   = 6'b001000;
    localparam logic [5:0] fnAdd  = 6'b100000;
    localparam logic [5:0] fnAddu = 6'b100001;
    localparam logic [5:0] fnSub  = 6'b100010;
    localparam logic [5:0] fnSubu = 6'b100011;
    localparam logic [5:0] fnAnd  = 6'b100100;
    localparam logic [5:0] fnOr   = 6'b100101;
    localparam logic [5:0] fnXor  = 6'b100110;
    localparam logic [5:0] fnNor  = 6'b100111;
    localparam logic [5:0] fnSlt  = 6'b101010;
    localparam logic [5:0] fnSltu = 6'b101011;

    typedef enum logic [3:0] {
        aluSll, aluSrl, aluSra, aluLui,
        aluAdd, aluSub, aluAnd, aluOr,
        aluXor, aluNor, aluSlt, aluSltu
    } aluOpT;

    typedef enum logic [1:0] {memByte, memHalf, memWord} memWidthT;

    typedef enum logic [1:0] {wbAlu, wbMem, wbLink} wbSrcT;

    typedef enum logic [1:0] {nextSeq, nextBranch, nextJump, nextReg} nextPcT;

    typedef struct packed {
        logic [5:0] opcode;
        regAddrT    rs;
        regAddrT    rt;
        regAddrT    rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rTypeT;

    typedef struct packed {
        logic [5:0]  opcode;
        regAddrT     rs;
        regAddrT     rt;
        logic [15:0] imm16;
    } iTypeT;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] target26;
    } jTypeT;

    // Same 32 bits seen as R, I or J format
    typedef union packed {
        rTypeT rType;
        iTypeT iType;
        jTypeT jType;
    } instrT;

    typedef struct packed {
        logic     regWrite;
        regAddrT  wbReg;          // Resolved destination
        aluOpT    aluOp;
        logic     useImm;         // Operand B from imm16
        logic     useShamt;       // Shift amount from shamt field
        logic     useVarShift;    // Shift amount from rs[4:0]
        logic     memWrite;
        memWidthT memWidth;
        logic     memSigned;
        wbSrcT    wbSrc;
        nextPcT   nextPc;
    } ctrlT;

    typedef struct packed {
        logic    wbValid;
        regAddrT wbReg;
        wordT    wbData;
    } retireT;

endpackage

// ==== design/controlDecoder.sv ====
module controlDecoder import cpuPkg::*; (
    input  instrT instr,
    input  logic  zero,
    input  logic  sign,
    output ctrlT  ctrl
);

    always_comb
    begin
        // Defaults give a harmless no-op that just steps pc
        ctrl.regWrite    = 1'b0;
        ctrl.wbReg       = instr.rType.rd;
        ctrl.aluOp       = aluAdd;
        ctrl.useImm      = 1'b0;
        ctrl.useShamt    = 1'b0;
        ctrl.useVarShift = 1'b0;
        ctrl.memWrite    = 1'b0;
        ctrl.memWidth    = memWord;
        ctrl.memSigned   = 1'b0;
        ctrl.wbSrc       = wbAlu;
        ctrl.nextPc      = nextSeq;

        case (instr.rType.opcode)
            opSpecial:
            begin
                ctrl.regWrite = 1'b1;                      // rd is destination
                case (instr.rType.funct)
                    fnSll:  begin ctrl.aluOp = aluSll; ctrl.useShamt = 1'b1; end
                    fnSrl:  begin ctrl.aluOp = aluSrl; ctrl.useShamt = 1'b1; end
                    fnSra:  begin ctrl.aluOp = aluSra; ctrl.useShamt = 1'b1; end
                    fnSllv: begin ctrl.aluOp = aluSll; ctrl.useVarShift = 1'b1; end
                    fnSrlv: begin ctrl.aluOp = aluSrl; ctrl.useVarShift = 1'b1; end
                    fnSrav: begin ctrl.aluOp = aluSra; ctrl.useVarShift = 1'b1; end
                    fnJr:
                    begin
                        ctrl.regWrite = 1'b0;
                        ctrl.nextPc   = nextReg;            // Target is rs
                    end
                    fnAdd, fnAddu: ctrl.aluOp = aluAdd;    // No overflow trap
                    fnSub, fnSubu: ctrl.aluOp = aluSub;
                    fnAnd:  ctrl.aluOp = aluAnd;
                    fnOr:   ctrl.aluOp = aluOr;
                    fnXor:  ctrl.aluOp = aluXor;
                    fnNor:  ctrl.aluOp = aluNor;
                    fnSlt:  ctrl.aluOp = aluSlt;
                    fnSltu: ctrl.aluOp = aluSltu;
                    default: ctrl.regWrite = 1'b0;         // Unknown funct
                endcase
            end
            opAddi, opAddiu, opSlti, opSltiu, opAndi, opOri, opXori, opLui:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.wbReg    = instr.iType.rt;
                ctrl.useImm   = 1'b1;
                case (instr.iType.opcode)
                    opSlti:  ctrl.aluOp = aluSlt;
                    opSltiu: ctrl.aluOp = aluSltu;
                    opAndi:  ctrl.aluOp = aluAnd;
                    opOri:   ctrl.aluOp = aluOr;
                    opXori:  ctrl.aluOp = aluXor;
                    opLui:   ctrl.aluOp = aluLui;
                    default: ctrl.aluOp = aluAdd;          // ADDI and ADDIU
                endcase
            end
            opBeq, opBne, opBlez, opBgtz:
            begin
                ctrl.aluOp = aluSub;                       // rs minus rt sets flags
                case (instr.iType.opcode)
                    opBeq:   ctrl.nextPc = zero ? nextBranch : nextSeq;
                    opBne:   ctrl.nextPc = !zero ? nextBranch : nextSeq;
                    opBlez:  ctrl.nextPc = (zero || sign) ? nextBranch : nextSeq;
                    default: ctrl.nextPc = !(zero || sign) ? nextBranch : nextSeq;
                endcase
            end
            opJ:
                ctrl.nextPc = nextJump;
            opJal:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.wbReg    = linkReg;
                ctrl.wbSrc    = wbLink;                    // Return address pc + 4
                ctrl.nextPc   = nextJump;
            end
            opLb, opLh, opLw, opLbu, opLhu:
            begin
                ctrl.regWrite  = 1'b1;
                ctrl.wbReg     = instr.iType.rt;
                ctrl.useImm    = 1'b1;                     // Base plus offset
                ctrl.wbSrc     = wbMem;
                ctrl.memSigned = (instr.iType.opcode == opLb) || (instr.iType.opcode == opLh);
                case (instr.iType.opcode)
                    opLb, opLbu: ctrl.memWidth = memByte;
                    opLh, opLhu: ctrl.memWidth = memHalf;
                    default:     ctrl.memWidth = memWord;
                endcase
            end
            opSb, opSh, opSw:
            begin
                ctrl.memWrite = 1'b1;
                ctrl.useImm   = 1'b1;
                case (instr.iType.opcode)
                    opSb:    ctrl.memWidth = memByte;
                    opSh:    ctrl.memWidth = memHalf;
                    default: ctrl.memWidth = memWord;
                endcase
            end
            default: ;                                     // Undefined opcode
        endcase

        if (ctrl.wbReg == '0)
            ctrl.regWrite = 1'b0;                          // $0 writes are dropped
    end

endmodule

// ==== design/fetchUnit.sv ====
module fetchUnit import cpuPkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  instrT instr,
    input  ctrlT  ctrl,
    input  wordT  rsData,
    output wordT  pc,
    output wordT  pcPlus4
);

    wordT branchOffset;
    wordT branchTarget;
    wordT jumpTarget;
    wordT pcNext;

    assign pcPlus4      = pc + 32'd4;
    assign branchOffset = {{14{instr.iType.imm16[15]}}, instr.iType.imm16, 2'b00}; // Words to bytes
    assign branchTarget = pcPlus4 + branchOffset;
    assign jumpTarget   = {pcPlus4[31:28], instr.jType.target26, 2'b00};          // Same 256 MB region

    always_comb
    begin
        case (ctrl.nextPc)
            nextBranch: pcNext = branchTarget;
            nextJump:   pcNext = jumpTarget;
            nextReg:    pcNext = rsData;                   // JR
            default:    pcNext = pcPlus4;
        endcase
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            pc <= '0;
        else
            pc <= pcNext;                                  // One instruction per edge
    end

    // A misaligned JR target would fetch garbage
    assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
        else $error("pc not word aligned: %h", pc);

endmodule

// ==== design/registerFile.sv ====
module registerFile import cpuPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  regAddrT rsAddr,
    input  regAddrT rtAddr,
    input  regAddrT wrAddr,
    input  logic    wrEnable,
    input  wordT    wrData,
    output wordT    rsData,
    output wordT    rtData
);

    wordT regs [regCount];

    // Asynchronous read, $0 hardwired
    assign rsData = (rsAddr != '0) ? regs[rsAddr] : '0;
    assign rtData = (rtAddr != '0) ? regs[rtAddr] : '0;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int i = 0; i < regCount; i++)
                regs[i] <= '0;
        end
        else if (wrEnable && (wrAddr != '0))
        begin
            regs[wrAddr] <= wrData;
        end
    end

    // Write enable is masked upstream in the top level during reset
    assert property (@(posedge clk) rst |-> !wrEnable)
        else $error("Register write requested during reset");

endmodule

// ==== design/executeUnit.sv ====
module executeUnit import cpuPkg::*; (
    input  instrT instr,
    input  ctrlT  ctrl,
    input  wordT  rsData,
    input  wordT  rtData,
    output wordT  aluResult,
    output logic  zero,
    output logic  sign
);

    wordT       immExt;
    wordT       srcA;
    wordT       srcB;
    logic [4:0] shiftAmt;

    assign immExt = {{16{instr.iType.imm16[15]}}, instr.iType.imm16}; // Logic ops too
    assign srcB   = ctrl.useImm ? immExt : rtData;

    always_comb
    begin
        if (ctrl.useShamt)
            srcA = {27'b0, instr.rType.shamt};             // Fixed shift
        else if (ctrl.useVarShift)
            srcA = {27'b0, rsData[4:0]};                   // Only low five bits count
        else
            srcA = rsData;
    end

    assign shiftAmt = srcA[4:0];

    always_comb
    begin
        case (ctrl.aluOp)
            aluSll:  aluResult = srcB << shiftAmt;
            aluSrl:  aluResult = srcB >> shiftAmt;
            aluSra:  aluResult = $signed(srcB) >>> shiftAmt;
            aluLui:  aluResult = {srcB[15:0], 16'b0};
            aluSub:  aluResult = srcA - srcB;              // Also branch compare
            aluAnd:  aluResult = srcA & srcB;
            aluOr:   aluResult = srcA | srcB;
            aluXor:  aluResult = srcA ^ srcB;
            aluNor:  aluResult = ~(srcA | srcB);
            aluSlt:  aluResult = {31'b0, $signed(srcA) < $signed(srcB)};
            aluSltu: aluResult = {31'b0, srcA < srcB};
            default: aluResult = srcA + srcB;              // Add and address calc
        endcase
    end

    // Flags feed the branch resolution
    assign zero = (aluResult == '0);
    assign sign = aluResult[dataWidth-1];

endmodule

// ==== design/memoryWriteback.sv ====
module memoryWriteback import cpuPkg::*; (
    input  logic clk,
    input  ctrlT ctrl,
    input  wordT aluResult,
    input  wordT rtData,
    input  wordT pcPlus4,
    output wordT wbData
);

    wordT                    ram [ramWords];
    logic [ramAddrWidth-1:0] wordIdx;
    logic [3:0]              byteEn;
    wordT                    storeData;
    wordT                    readWord;
    logic [7:0]              laneByte;
    logic [15:0]             laneHalf;
    wordT                    loadData;

    assign wordIdx = aluResult[2 +: ramAddrWidth];         // Upper address bits wrap

    // Replicate store data so every lane sees the right bits
    always_comb
    begin
        case (ctrl.memWidth)
            memByte:
            begin
                byteEn                 = 4'b0000;
                byteEn[aluResult[1:0]] = 1'b1;
                storeData              = {4{rtData[7:0]}};
            end
            memHalf:
            begin
                byteEn    = aluResult[1] ? 4'b1100 : 4'b0011;
                storeData = {2{rtData[15:0]}};
            end
            default:
            begin
                byteEn    = 4'b1111;
                storeData = rtData;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (ctrl.memWrite)
        begin
            for (int i = 0; i < 4; i++)
            begin
                if (byteEn[i])
                    ram[wordIdx][i*8 +: 8] <= storeData[i*8 +: 8];
            end
        end
    end

    // Combinational read, lane picked by low address bits
    assign readWord = ram[wordIdx];
    assign laneByte = readWord[{aluResult[1:0], 3'b000} +: 8];
    assign laneHalf = aluResult[1] ? readWord[31:16] : readWord[15:0];

    always_comb
    begin
        case (ctrl.memWidth)
            memByte: loadData = {{24{ctrl.memSigned & laneByte[7]}}, laneByte};
            memHalf: loadData = {{16{ctrl.memSigned & laneHalf[15]}}, laneHalf};
            default: loadData = readWord;
        endcase
    end

    always_comb
    begin
        case (ctrl.wbSrc)
            wbMem:   wbData = loadData;
            wbLink:  wbData = pcPlus4;                     // JAL return address
            default: wbData = aluResult;
        endcase
    end

    // Half needs even address, word needs both low bits clear
    assert property (@(posedge clk)
        ((ctrl.memWrite || ctrl.wbSrc == wbMem) && ctrl.memWidth != memByte)
            |-> (!aluResult[0] && (ctrl.memWidth == memHalf || !aluResult[1])))
        else $error("Misaligned memory access at %h", aluResult);

endmodule

// ==== design/cpuTop.sv ====
module cpuTop import cpuPkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  instrT  instr,
    output wordT   pc,
    output retireT retire
);

    ctrlT ctrl;                                            // Raw decode
    ctrlT ctrlCommit;                                      // Writes held off in reset
    wordT pcPlus4;
    wordT rsData;
    wordT rtData;
    wordT aluResult;
    wordT wbData;
    logic zero;
    logic sign;

    always_comb
    begin
        ctrlCommit = ctrl;
        if (rst)
        begin
            ctrlCommit.regWrite = 1'b0;
            ctrlCommit.memWrite = 1'b0;
        end
    end

    assign retire.wbValid = ctrlCommit.regWrite;
    assign retire.wbReg   = ctrl.wbReg;
    assign retire.wbData  = wbData;

    controlDecoder decoder (
        .instr(instr), .zero(zero), .sign(sign), .ctrl(ctrl)
    );

    fetchUnit fetch (
        .clk(clk), .rst(rst), .instr(instr), .ctrl(ctrl),
        .rsData(rsData), .pc(pc), .pcPlus4(pcPlus4)
    );

    registerFile regFile (
        .clk(clk), .rst(rst),
        .rsAddr(instr.rType.rs), .rtAddr(instr.rType.rt),
        .wrAddr(ctrl.wbReg), .wrEnable(ctrlCommit.regWrite), .wrData(wbData),
        .rsData(rsData), .rtData(rtData)
    );

    executeUnit execute (
        .instr(instr), .ctrl(ctrl), .rsData(rsData), .rtData(rtData),
        .aluResult(aluResult), .zero(zero), .sign(sign)
    );

    memoryWriteback memWb (
        .clk(clk), .ctrl(ctrlCommit), .aluResult(aluResult),
        .rtData(rtData), .pcPlus4(pcPlus4), .wbData(wbData)
    );

endmodule

// ==== tests/cpuTbTasks.svh ====
`ifndef CPU_TB_TASKS_SVH
`define CPU_TB_TASKS_SVH

function automatic wordT rFormat(logic [5:0] funct, regAddrT rs, regAddrT rt, regAddrT rd,
                                 logic [4:0] shamt);
    return {opSpecial, rs, rt, rd, shamt, funct};
endfunction

function automatic wordT iFormat(logic [5:0] op, regAddrT rs, regAddrT rt, logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

function automatic wordT jFormat(logic [5:0] op, logic [25:0] target);
    return {op, target};
endfunction

function automatic wordT signExtend16(logic [15:0] v);
    return {{16{v[15]}}, v};
endfunction

// Signed compare built from sign bits and an unsigned compare
function automatic logic lessSigned(wordT a, wordT b);
    return (a[31] != b[31]) ? a[31] : (a < b);
endfunction

function automatic wordT shiftRightArith(wordT v, int n);
    return (v >> n) | (v[31] ? ~(32'hFFFF_FFFF >> n) : '0);  // Refill with sign
endfunction

task automatic checkValue(string name, wordT expected, wordT actual);
    checkCount++;
    if (expected !== actual)
    begin
        errorCount++;
        $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
    end
endtask

task automatic place(wordT word);
    prog.push_back(word);                                  // Next ROM address
endtask

task automatic expectStep(wordT pcVal, logic valid, regAddrT wbReg, wordT wbData);
    traceT step;
    step.pc          = pcVal;
    step.ret.wbValid = valid;
    step.ret.wbReg   = wbReg;
    step.ret.wbData  = wbData;
    trace.push_back(step);
endtask

// Place an instruction that runs in program order
task automatic emit(wordT word, logic valid, regAddrT wbReg, wordT wbData);
    expectStep(prog.size() * 4, valid, wbReg, wbData);
    place(word);
endtask

// Holds reset while the ROM is reloaded, checks reset state
task loadAndReset(string name);
    int i;
    @(posedge clk);
    rst <= 1'b1;
    for (i = 0; i < romWords; i++)
        rom[i] <= (i < prog.size()) ? prog[i] : '0;        // Zero outside program
    repeat (resetCycles)
    begin
        @(negedge clk);
        checkValue({name, " reset pc"}, '0, pc);
        checkValue({name, " reset wbValid"}, '0, retire.wbValid);
        @(posedge clk);
    end
    rst <= 1'b0;
endtask

task runProgram(string name);
    int i;
    loadAndReset(name);
    for (i = 0; i < trace.size(); i++)
    begin
        @(negedge clk);                                    // Outputs settled
        checkValue($sformatf("%s step %0d pc", name, i), trace[i].pc, pc);
        checkValue($sformatf("%s step %0d wbValid", name, i), trace[i].ret.wbValid,
                   retire.wbValid);
        if (trace[i].ret.wbValid)
        begin
            checkValue($sformatf("%s step %0d wbReg", name, i), trace[i].ret.wbReg,
                       retire.wbReg);
            checkValue($sformatf("%s step %0d wbData", name, i), trace[i].ret.wbData,
                       retire.wbData);
        end
    end
    prog.delete();
    trace.delete();
endtask

task automatic waitPc(string name, wordT target, int limit);
    int cycles;
    cycles = 0;
    while (pc !== target && cycles < limit)
    begin
        @(negedge clk);
        cycles++;
    end
    if (pc !== target)
    begin
        errorCount++;
        $display("%s: pc never reached %h within %0d cycles", name, target, limit);
    end
endtask

task resetTest;
    int k;
    loadAndReset("reset");                                 // Empty program, all zero words
    for (k = 0; k < 8; k++)
    begin
        @(negedge clk);
        checkValue("reset run pc", k * 4, pc);
        checkValue("reset run wbValid", '0, retire.wbValid);
    end
    waitPc("reset", 32'h40, 20);
endtask

task aluTest;
    wordT        a;
    wordT        b;
    logic [15:0] immA;
    logic [15:0] immB;
    a    = $urandom;
    b    = $urandom;
    immA = a[15:0];
    immB = b[15:0];
    a    = signExtend16(immA);
    b    = signExtend16(immB);
    emit(iFormat(opAddi, 0, 1, immA), 1, 1, a);
    emit(iFormat(opAddi, 0, 2, immB), 1, 2, b);
    emit(rFormat(fnAdd, 1, 2, 3, 0), 1, 3, a + b);
    emit(rFormat(fnSub, 1, 2, 4, 0), 1, 4, a - b);
    emit(rFormat(fnAnd, 1, 2, 5, 0), 1, 5, a & b);
    emit(rFormat(fnOr, 1, 2, 6, 0), 1, 6, a | b);
    emit(rFormat(fnXor, 1, 2, 7, 0), 1, 7, a ^ b);
    emit(rFormat(fnNor, 1, 2, 8, 0), 1, 8, ~(a | b));
    emit(rFormat(fnSlt, 1, 2, 9, 0), 1, 9, lessSigned(a, b));
    emit(rFormat(fnSltu, 1, 2, 10, 0), 1, 10, a < b);
    emit(rFormat(fnAddu, 1, 2, 11, 0), 1, 11, a + b);
    emit(rFormat(fnSubu, 1, 2, 12, 0), 1, 12, a - b);
    emit(iFormat(opAddiu, 1, 13, immB), 1, 13, a + b);
    emit(iFormat(opSlti, 1, 14, immB), 1, 14, lessSigned(a, b));
    emit(iFormat(opSltiu, 1, 15, immB), 1, 15, a < b);   // Immediate sign-extended first
    emit(iFormat(opAndi, 1, 16, immB), 1, 16, a & b);
    emit(iFormat(opOri, 1, 17, immB), 1, 17, a | b);
    emit(iFormat(opXori, 1, 18, immB), 1, 18, a ^ b);
    emit(rFormat(fnAdd, 1, 2, 0, 0), 0, 0, '0);           // $0 destination
    emit(iFormat(opAddi, 1, 0, immB), 0, 0, '0);
    runProgram("alu");
endtask

task shiftTest;
    wordT v;
    v = 32'hFFFF_8421;
    emit(iFormat(opAddi, 0, 1, 16'h8421), 1, 1, v);
    emit(iFormat(opAddi, 0, 2, 16'd36), 1, 2, 32'd36);   // Low five bits give 4
    emit(rFormat(fnSll, 0, 1, 3, 5), 1, 3, v << 5);
    emit(rFormat(fnSrl, 0, 1, 4, 5), 1, 4, v >> 5);
    emit(rFormat(fnSra, 0, 1, 5, 5), 1, 5, shiftRightArith(v, 5));
    emit(rFormat(fnSllv, 2, 1, 6, 0), 1, 6, v << 4);
    emit(rFormat(fnSrlv, 2, 1, 7, 0), 1, 7, v >> 4);
    emit(rFormat(fnSrav, 2, 1, 8, 0), 1, 8, shiftRightArith(v, 4));
    emit(iFormat(opLui, 0, 9, 16'hA5C3), 1, 9, 32'hA5C3_0000);
    runProgram("shift");
endtask

task memoryTest;
    emit(iFormat(opAddi, 0, 1, 16'h0040), 1, 1, 32'h40);  // Base address
    emit(iFormat(opLui, 0, 2, 16'h8765), 1, 2, 32'h8765_0000);
    emit(iFormat(opOri, 2, 2, 16'h4321), 1, 2, 32'h8765_4321);
    emit(iFormat(opAddi, 0, 3, 16'hFFA5), 1, 3, 32'hFFFF_FFA5);
    emit(iFormat(opSw, 1, 2, 16'd0), 0, 0, '0);
    emit(iFormat(opSw, 1, 2, 16'd4), 0, 0, '0);
    emit(iFormat(opSh, 1, 3, 16'd6), 0, 0, '0);           // Upper half of 0x44
    emit(iFormat(opSw, 1, 2, 16'd8), 0, 0, '0);
    emit(iFormat(opSb, 1, 3, 16'd9), 0, 0, '0);           // Byte 1 of 0x48
    emit(iFormat(opLw, 1, 4, 16'd0), 1, 4, 32'h8765_4321);
    emit(iFormat(opLh, 1, 5, 16'd6), 1, 5, 32'hFFFF_FFA5);
    emit(iFormat(opLhu, 1, 6, 16'd6), 1, 6, 32'h0000_FFA5);
    emit(iFormat(opLh, 1, 7, 16'd4), 1, 7, 32'h0000_4321);
    emit(iFormat(opLb, 1, 8, 16'd9), 1, 8, 32'hFFFF_FFA5);
    emit(iFormat(opLbu, 1, 9, 16'd9), 1, 9, 32'h0000_00A5);
    emit(iFormat(opLb, 1, 10, 16'd11), 1, 10, 32'hFFFF_FF87);
    emit(iFormat(opLbu, 1, 11, 16'd8), 1, 11, 32'h0000_0021);
    emit(iFormat(opLw, 1, 12, 16'd8), 1, 12, 32'h8765_A521);
    emit(iFormat(opLw, 1, 13, 16'd4), 1, 13, 32'hFFA5_4321);
    runProgram("memory");
endtask

// Offset 2 skips two filler words when taken
task branchStep(logic [5:0] op, regAddrT rs, regAddrT rt, wordT rsVal, wordT rtVal);
    logic taken;
    case (op)
        opBeq:   taken = (rsVal == rtVal);
        opBne:   taken = (rsVal != rtVal);
        opBlez:  taken = rsVal[31] || (rsVal == '0);
        default: taken = !rsVal[31] && (rsVal != '0);
    endcase
    emit(iFormat(op, rs, rt, 16'd2), 0, 0, '0);
    if (taken)
    begin
        place(iFormat(opAddi, 0, 20, 16'h0BAD));           // Must be skipped
        place(iFormat(opAddi, 0, 21, 16'h0BAD));
    end
endtask

task branchTest;
    wordT pos;
    wordT neg;
    pos = 32'd5;
    neg = 32'hFFFF_FFFD;
    emit(iFormat(opAddi, 0, 1, 16'd5), 1, 1, pos);
    emit(iFormat(opAddi, 0, 2, 16'hFFFD), 1, 2, neg);
    branchStep(opBeq, 1, 1, pos, pos);
    branchStep(opBeq, 1, 2, pos, neg);
    branchStep(opBeq, 0, 0, '0, '0);
    branchStep(opBne, 1, 2, pos, neg);
    branchStep(opBne, 2, 2, neg, neg);
    branchStep(opBlez, 0, 0, '0, '0);
    branchStep(opBlez, 2, 0, neg, '0);
    branchStep(opBlez, 1, 0, pos, '0);
    branchStep(opBgtz, 1, 0, pos, '0);
    branchStep(opBgtz, 0, 0, '0, '0);
    branchStep(opBgtz, 2, 0, neg, '0);
    emit(iFormat(opAddi, 0, 4, 16'd9), 1, 4, 32'd9);      // Landing after last branch
    runProgram("branch");
endtask

task jumpTest;
    place(jFormat(opJ, 26'd3));                            // 0x00 to 0x0C
    place(iFormat(opAddi, 0, 20, 16'h0BAD));
    place(iFormat(opAddi, 0, 21, 16'h0BAD));
    place(jFormat(opJal, 26'd6));                          // 0x0C calls 0x18
    place(iFormat(opAddi, 0, 5, 16'd7));                   // 0x10 return point
    place(jFormat(opJ, 26'd8));                            // 0x14 to 0x20
    place(iFormat(opAddi, 0, 6, 16'd3));                   // 0x18 subroutine
    place(rFormat(fnJr, 31, 0, 0, 0));                     // 0x1C back to link
    place(iFormat(opAddi, 0, 7, 16'd1));                   // 0x20
    expectStep(32'h00, 0, 0, '0);
    expectStep(32'h0C, 1, linkReg, 32'h10);                // Link is pc plus 4
    expectStep(32'h18, 1, 6, 32'd3);
    expectStep(32'h1C, 0, 0, '0);
    expectStep(32'h10, 1, 5, 32'd7);
    expectStep(32'h14, 0, 0, '0);
    expectStep(32'h20, 1, 7, 32'd1);
    runProgram("jump");
endtask

`endif

// ==== tests/cpuTb.sv ====
module cpuTb import cpuPkg::*; ();

    localparam int romWords    = 256;                      // Instruction words modelled
    localparam int resetCycles = 4;
    localparam int runLimit    = 100000;                   // Whole-run time budget

    // One expected cycle: pc and what retires there
    typedef struct packed {
        wordT   pc;
        retireT ret;
    } traceT;

    logic   clk;
    logic   rst;
    instrT  instr;
    wordT   pc;
    retireT retire;

    wordT   rom [romWords];                                // Instruction ROM model
    wordT   prog [$];                                      // Program being assembled
    traceT  trace [$];                                     // Expected execution order
    int     checkCount;
    int     errorCount;

    // Combinational fetch, zero past the ROM
    assign instr = (pc[31:2] < romWords) ? rom[pc[31:2]] : '0;

    cpuTop UUT (
        .clk(clk),
        .rst(rst),
        .instr(instr),
        .pc(pc),
        .retire(retire)
    );

    `include "cpuTbTasks.svh"

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;                             // Period 10
    end

    initial
    begin : watchdog
        #runLimit;
        $display("Run exceeded its time limit before all tests finished");
        $display("STATUS: FAIL");
        $finish;
    end

    initial
    begin
        void'($urandom(32'h0628_e8a5));                   // Single seed for the run
        rst        = 1'b1;
        checkCount = 0;
        errorCount = 0;
        for (int i = 0; i < romWords; i++)
            rom[i] = '0;

        resetTest();
        aluTest();
        shiftTest();
        memoryTest();
        branchTest();
        jumpTest();

        $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+tests
design/cpuPkg.sv
design/controlDecoder.sv
design/fetchUnit.sv
design/registerFile.sv
design/executeUnit.sv
design/memoryWriteback.sv
design/cpuTop.sv
tests/cpuTb.sv
